// ==== gemac_tx.f ====
+incdir+src
src/gemac_types_pkg.sv
src/gemac_tx_state_pkg.sv
src/gemac_crc32.sv
src/gemac_tx_framer.sv
src/gemac_pause_timer.sv
src/gemac_tx_top.sv
test/tb_clock_gen.sv
test/tb_gemac_tx.sv

// ==== src/gemac_crc32.sv ====
`timescale 1ns/1ps

`include "gemac_tx_defines.svh"

module gemac_crc32
(
   input  logic                        tx_clk,
   input  logic                        reset,
   input  logic                        crc_clear,
   input  logic                        crc_calc,
   input  gemac_types_pkg::gemac_byte_t crc_data,
   output gemac_types_pkg::crc32_t     crc_value
);

   import gemac_types_pkg::*;

   crc32_t crc_reg;   // reflected register, lsb is x^31

   // fold one byte in, lsb first
   function automatic crc32_t crc_next(input crc32_t crc, input gemac_byte_t data);
      crc32_t r;
      r = crc ^ {24'h0, data};
      for (int i = 0; i < 8; i++)
      begin
         if (r[0])
            r = (r >> 1) ^ `GEMAC_CRC32_POLY;
         else
            r = r >> 1;
      end
      return r;
   endfunction

   always_ff @(posedge tx_clk)
   begin
      if (reset || crc_clear)
         crc_reg <= '1;                              // preset to all ones
      else if (crc_calc)
         crc_reg <= crc_next(crc_reg, crc_data);
   end

   // first gmii byte of the fcs sits in [31:24]
   assign crc_value = ~{crc_reg[7:0], crc_reg[15:8], crc_reg[23:16], crc_reg[31:24]};

   a_clear_calc_excl: assert property (@(posedge tx_clk) disable iff (reset)
      !(crc_clear && crc_calc))
      else $error("crc_clear and crc_calc high in the same cycle");

endmodule

// ==== src/gemac_pause_timer.sv ====
`timescale 1ns/1ps

`include "gemac_tx_defines.svh"

module gemac_pause_timer
(
   input  logic                         tx_clk,
   input  logic                         reset,
   input  logic                         pause_rcvd,
   input  gemac_types_pkg::pause_time_t pause_quanta,
   output logic                         pause_apply
);

   import gemac_types_pkg::*;

   localparam int presc_w = $clog2(`GEMAC_QUANTUM_CYCLES);
   localparam logic [presc_w-1:0] presc_last = presc_w'(`GEMAC_QUANTUM_CYCLES - 1);

   pause_time_t        quanta_ctr;   // quanta still to wait
   logic [presc_w-1:0] presc;        // clocks left in the current quantum

   always_ff @(posedge tx_clk)
   begin
      if (reset)
      begin
         quanta_ctr <= '0;
         presc      <= '0;
      end
      else if (pause_rcvd)
      begin
         quanta_ctr <= pause_quanta;                // reload, zero releases at once
         presc      <= presc_last;
      end
      else if (quanta_ctr != '0)
      begin
         if (presc == '0)
         begin
            quanta_ctr <= quanta_ctr - 1'b1;
            presc      <= presc_last;
         end
         else
         begin
            presc <= presc - 1'b1;
         end
      end
   end

   assign pause_apply = (quanta_ctr != '0);

   a_zero_quanta: assert property (@(posedge tx_clk) disable iff (reset)
      (pause_rcvd && pause_quanta == '0) |=> !pause_apply)
      else $error("pause_apply still high after a zero-quanta pause");

endmodule

// ==== src/gemac_tx_defines.svh ====
`ifndef GEMAC_TX_DEFINES_SVH
`define GEMAC_TX_DEFINES_SVH

// frame lengths in byte times, counted from the first preamble byte
`define GEMAC_PREAMBLE_LEN    8               // 7 x 55 plus the d5 delimiter
`define GEMAC_MIN_FRAME_LEN   68              // 60 frame bytes + preamble, no fcs
`define GEMAC_PAUSE_HDR_LEN   18              // da, sa, type, opcode, time

`define GEMAC_IFG_RESET       100             // gap count loaded at reset
`define GEMAC_QUANTUM_CYCLES  64              // 512 bit times at 8 bits per clock

`define GEMAC_FLOW_CTRL_ADDR  48'h01_80_C2_00_00_01
`define GEMAC_CTRL_TYPE       16'h8808        // mac control ethertype
`define GEMAC_PAUSE_OPCODE    16'h0001

`define GEMAC_CRC32_POLY      32'hEDB8_8320   // reflected 802.3 polynomial

`endif

// ==== src/gemac_tx_framer.sv ====
`timescale 1ns/1ps

`include "gemac_tx_defines.svh"

module gemac_tx_framer
(
   input  logic                         tx_clk,
   input  logic                         reset,
   input  gemac_types_pkg::gemac_byte_t tx_data,
   input  logic                         tx_valid,
   input  logic                         tx_error,
   output logic                         tx_ack,
   input  gemac_types_pkg::ifg_t        ifg,
   input  gemac_types_pkg::mac_addr_t   mac_addr,
   input  logic                         pause_req,
   input  gemac_types_pkg::pause_time_t pause_time,
   input  logic                         pause_apply,
   output logic                         paused,
   output logic                         crc_clear,
   output logic                         crc_calc,
   output gemac_types_pkg::gemac_byte_t crc_data,
   input  gemac_types_pkg::crc32_t      crc_value,
   output logic                         gmii_tx_en,
   output logic                         gmii_tx_er,
   output gemac_types_pkg::gemac_byte_t gmii_txd
);

   import gemac_types_pkg::*;
   import gemac_tx_state_pkg::*;

   localparam frame_len_t preamble_last = frame_len_t'(`GEMAC_PREAMBLE_LEN - 2);
   localparam frame_len_t min_last      = frame_len_t'(`GEMAC_MIN_FRAME_LEN - 1);
   localparam frame_len_t min_len       = frame_len_t'(`GEMAC_MIN_FRAME_LEN);
   localparam pause_idx_t pause_idx_last = pause_idx_t'(`GEMAC_PAUSE_HDR_LEN - 1);

   tx_state_t   state;
   tx_state_t   state_next;
   frame_len_t  frame_len;
   ifg_t        ifg_ctr;
   logic        in_ifg;
   logic        send_pause;
   pause_time_t pause_time_held;
   pause_idx_t  pause_idx;
   gemac_byte_t pause_byte;
   logic [8*`GEMAC_PAUSE_HDR_LEN-1:0] pause_hdr;
   logic        tx_en_pre;
   logic        tx_er_pre;
   gemac_byte_t txd_pre;                  // one cycle ahead of gmii

   assign in_ifg = (ifg_ctr != '0);

   always_comb
   begin
      state_next = state;
      case (state)
         st_idle:
            if (!in_ifg)
            begin
               if (send_pause)                           // pause frame goes first
                  state_next = st_pause_preamble;
               else if (tx_valid && !pause_apply)
                  state_next = st_preamble;
            end
         st_preamble:
            if (frame_len == preamble_last)
               state_next = st_sof;
         st_sof:
            state_next = st_first_byte;
         st_first_byte:
            if (tx_error)
               state_next = st_error;                    // underrun
            else if (!tx_valid)
               state_next = st_pad;
            else
               state_next = st_in_frame;
         st_in_frame:
            if (tx_error)
               state_next = st_error;
            else if (!tx_valid)
               state_next = st_pad;
            else if (frame_len == min_last)
               state_next = st_in_frame_min;
         st_in_frame_min:
            if (tx_error)
               state_next = st_error;
            else if (!tx_valid)
               state_next = st_crc_0;
         st_pad:
            if (frame_len == min_len)
               state_next = st_crc_0;
         st_crc_0:
            state_next = st_crc_1;
         st_crc_1:
            state_next = st_crc_2;
         st_crc_2:
            state_next = st_crc_3;
         st_crc_3:
            state_next = st_idle;
         st_error:
            state_next = st_idle;
         st_pause_preamble:
            if (frame_len == preamble_last)
               state_next = st_pause_sof;
         st_pause_sof:
            state_next = st_pause_body;
         st_pause_body:
            if (pause_idx == pause_idx_last)
               state_next = st_pad;                      // zero fill to 60 bytes
         default:
            state_next = st_idle;
      endcase
   end

   always_ff @(posedge tx_clk)
   begin
      if (reset)
         state <= st_idle;
      else
         state <= state_next;
   end

   always_ff @(posedge tx_clk)
   begin
      if (reset || state == st_idle)
         frame_len <= '0;
      else
         frame_len <= frame_len + 1'b1;
   end

   // gap restarts after a good frame and after an underrun
   always_ff @(posedge tx_clk)
   begin
      if (reset)
         ifg_ctr <= ifg_t'(`GEMAC_IFG_RESET);
      else if (state == st_crc_3 || state == st_error)
         ifg_ctr <= ifg;
      else if (in_ifg)
         ifg_ctr <= ifg_ctr - 1'b1;
   end

   always_ff @(posedge tx_clk)
   begin
      if (reset)
         send_pause <= 1'b0;
      else if (pause_req)
         send_pause <= 1'b1;
      else if (state == st_pause_preamble)
         send_pause <= 1'b0;
   end

   always_ff @(posedge tx_clk)
   begin
      if (pause_req)
         pause_time_held <= pause_time;
   end

   // header bytes in wire order, first byte at the top
   assign pause_hdr = {`GEMAC_FLOW_CTRL_ADDR, mac_addr, `GEMAC_CTRL_TYPE,
                       `GEMAC_PAUSE_OPCODE, pause_time_held};
   assign pause_idx = pause_idx_t'(frame_len - frame_len_t'(`GEMAC_PREAMBLE_LEN));
   assign pause_byte = pause_hdr[8*(`GEMAC_PAUSE_HDR_LEN-1-pause_idx) +: 8];

   always_ff @(posedge tx_clk)
   begin
      if (reset)
      begin
         tx_en_pre <= 1'b0;
         tx_er_pre <= 1'b0;
      end
      else
      begin
         case (state)
            st_idle:
            begin
               tx_en_pre <= 1'b0;
               tx_er_pre <= 1'b0;
            end
            st_preamble, st_pause_preamble:
               tx_en_pre <= 1'b1;
            st_error:
               tx_er_pre <= 1'b1;
            st_crc_3:
               tx_en_pre <= 1'b0;
            default:
               tx_en_pre <= tx_en_pre;
         endcase
      end
   end

   always_ff @(posedge tx_clk)
   begin
      case (state)
         st_idle, st_pad, st_error:
            txd_pre <= 8'h00;
         st_preamble, st_pause_preamble:
            txd_pre <= 8'h55;
         st_sof, st_pause_sof:
            txd_pre <= 8'hD5;
         st_first_byte, st_in_frame, st_in_frame_min:
            txd_pre <= tx_valid ? tx_data : 8'h00;
         st_pause_body:
            txd_pre <= pause_byte;
         default:
            txd_pre <= txd_pre;                          // don't care under the fcs
      endcase
   end

   assign crc_clear = (state == st_idle);
   assign crc_calc  = (state == st_in_frame) || (state == st_in_frame_min) ||
                      (state == st_pad) || (state == st_pause_body && pause_idx != '0);
   assign crc_data  = txd_pre;

   assign tx_ack = (state == st_first_byte);

   always_ff @(posedge tx_clk)
   begin
      if (reset)
      begin
         gmii_tx_en <= 1'b0;
         gmii_tx_er <= 1'b0;
      end
      else
      begin
         gmii_tx_en <= tx_en_pre;
         gmii_tx_er <= tx_er_pre;
      end
   end

   // fcs replaces the pre-output byte, msb first
   always_ff @(posedge tx_clk)
   begin
      case (state)
         st_crc_0: gmii_txd <= crc_value[31:24];
         st_crc_1: gmii_txd <= crc_value[23:16];
         st_crc_2: gmii_txd <= crc_value[15:8];
         st_crc_3: gmii_txd <= crc_value[7:0];
         default:  gmii_txd <= txd_pre;
      endcase
   end

   // only reported once the framer is back in idle
   always_ff @(posedge tx_clk)
   begin
      if (reset)
         paused <= 1'b0;
      else if (!pause_apply)
         paused <= 1'b0;
      else if (state == st_idle)
         paused <= 1'b1;
   end

   a_er_inside_en: assert property (@(posedge tx_clk) disable iff (reset)
      gmii_tx_er |-> gmii_tx_en)
      else $error("gmii_tx_er high without gmii_tx_en");

   a_ack_single: assert property (@(posedge tx_clk) disable iff (reset)
      tx_ack |=> !tx_ack)
      else $error("tx_ack high for two cycles in a row");

endmodule

// ==== src/gemac_tx_state_pkg.sv ====
package gemac_tx_state_pkg;

   // framer sequencing states
   typedef enum logic [4:0]
   {
      st_idle,
      st_preamble,         // seven 55 bytes
      st_sof,              // d5 delimiter
      st_first_byte,       // acks the client
      st_in_frame,
      st_in_frame_min,     // minimum length reached
      st_pad,
      st_crc_0,
      st_crc_1,
      st_crc_2,
      st_crc_3,
      st_error,            // underrun byte with tx_er
      st_pause_preamble,
      st_pause_sof,
      st_pause_body        // 18 header bytes
   } tx_state_t;

   // byte position within the pause header
   typedef logic [4:0] pause_idx_t;

endpackage

// ==== src/gemac_tx_top.sv ====
`timescale 1ns/1ps

module gemac_tx_top
(
   input  logic                         tx_clk,
   input  logic                         reset,
   input  gemac_types_pkg::gemac_byte_t tx_data,
   input  logic                         tx_valid,
   input  logic                         tx_error,
   output logic                         tx_ack,
   input  gemac_types_pkg::ifg_t        ifg,
   input  gemac_types_pkg::mac_addr_t   mac_addr,
   input  logic                         pause_req,
   input  gemac_types_pkg::pause_time_t pause_time,
   input  logic                         pause_rcvd,
   input  gemac_types_pkg::pause_time_t pause_quanta,
   output logic                         paused,
   output logic                         gmii_tx_en,
   output logic                         gmii_tx_er,
   output gemac_types_pkg::gemac_byte_t gmii_txd
);

   import gemac_types_pkg::*;

   logic        crc_clear;
   logic        crc_calc;
   gemac_byte_t crc_data;
   crc32_t      crc_value;
   logic        pause_apply;   // hold-off from the received pause

   gemac_tx_framer i_framer (
      .tx_clk      (tx_clk),
      .reset       (reset),
      .tx_data     (tx_data),
      .tx_valid    (tx_valid),
      .tx_error    (tx_error),
      .tx_ack      (tx_ack),
      .ifg         (ifg),
      .mac_addr    (mac_addr),
      .pause_req   (pause_req),
      .pause_time  (pause_time),
      .pause_apply (pause_apply),
      .paused      (paused),
      .crc_clear   (crc_clear),
      .crc_calc    (crc_calc),
      .crc_data    (crc_data),
      .crc_value   (crc_value),
      .gmii_tx_en  (gmii_tx_en),
      .gmii_tx_er  (gmii_tx_er),
      .gmii_txd    (gmii_txd)
   );

   gemac_crc32 i_crc (
      .tx_clk    (tx_clk),
      .reset     (reset),
      .crc_clear (crc_clear),
      .crc_calc  (crc_calc),
      .crc_data  (crc_data),
      .crc_value (crc_value)
   );

   gemac_pause_timer i_pause_timer (
      .tx_clk       (tx_clk),
      .reset        (reset),
      .pause_rcvd   (pause_rcvd),
      .pause_quanta (pause_quanta),
      .pause_apply  (pause_apply)
   );

endmodule

// ==== src/gemac_types_pkg.sv ====
package gemac_types_pkg;

   // one byte on gmii or the client side
   typedef logic [7:0] gemac_byte_t;

   // station or multicast address
   typedef logic [47:0] mac_addr_t;

   // crc register and fcs
   typedef logic [31:0] crc32_t;

   // inter-frame gap in byte times
   typedef logic [7:0] ifg_t;

   // pause quanta, sent or received
   typedef logic [15:0] pause_time_t;

   // bytes since the first preamble byte
   typedef logic [15:0] frame_len_t;

endpackage

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen
(
   output logic tx_clk,
   output logic reset
);

   initial
   begin
      tx_clk = 1'b0;
      forever #50 tx_clk = ~tx_clk;       // 100 ns period
   end

   initial
   begin
      reset = 1'b1;
      repeat (16) @(posedge tx_clk);
      #1 reset = 1'b0;                     // released like any other input
   end

endmodule

// ==== test/tb_gemac_tx.sv ====
`timescale 1ns/1ps

`include "gemac_tx_defines.svh"

module tb_gemac_tx;

   import gemac_types_pkg::*;

   localparam int max_rows   = 16;
   localparam int max_frames = 32;
   localparam int body_min   = `GEMAC_MIN_FRAME_LEN - 8;   // frame bytes before the fcs

   logic        tx_clk;
   logic        reset;
   gemac_byte_t tx_data;
   logic        tx_valid;
   logic        tx_error;
   logic        tx_ack;
   ifg_t        ifg;
   mac_addr_t   mac_addr;
   logic        pause_req;
   pause_time_t pause_time;
   logic        pause_rcvd;
   pause_time_t pause_quanta;
   logic        paused;
   logic        gmii_tx_en;
   logic        gmii_tx_er;
   gemac_byte_t gmii_txd;

   // stimulus table, one row per test
   int row_len [max_rows];
   int row_seed [max_rows];
   int row_ifg [max_rows];
   int row_err [max_rows];       // payload index carrying tx_error, -1 for none
   int row_preq [max_rows];
   int row_ptime [max_rows];
   int row_quanta [max_rows];    // 0 means no pause_rcvd pulse
   int n_rows;

   // frames seen on gmii
   gemac_byte_t cap_txd [max_frames][256];
   logic        cap_er [max_frames][256];
   int          cap_len [max_frames];
   int          cap_start [max_frames];
   int          cap_end [max_frames];
   int          cap_ifg [max_frames];
   logic        cap_paused [max_frames];
   int          frame_count;
   int          frames_wanted;
   int          byte_idx;
   bit          capturing;

   gemac_byte_t payload [256];
   gemac_byte_t body [256];
   int          body_len;
   gemac_byte_t exp_txd [300];
   logic        exp_er [300];
   int          exp_len;

   int     cycle;
   int     cycle_limit;
   int     ack_count;
   bit     paused_seen;
   int     checks;
   int     errors;
   integer seed;

   tb_clock_gen i_clk_gen (.tx_clk(tx_clk), .reset(reset));

   gemac_tx_top i_dut (
      .tx_clk       (tx_clk),
      .reset        (reset),
      .tx_data      (tx_data),
      .tx_valid     (tx_valid),
      .tx_error     (tx_error),
      .tx_ack       (tx_ack),
      .ifg          (ifg),
      .mac_addr     (mac_addr),
      .pause_req    (pause_req),
      .pause_time   (pause_time),
      .pause_rcvd   (pause_rcvd),
      .pause_quanta (pause_quanta),
      .paused       (paused),
      .gmii_tx_en   (gmii_tx_en),
      .gmii_tx_er   (gmii_tx_er),
      .gmii_txd     (gmii_txd)
   );

   always @(posedge tx_clk)
   begin
      cycle <= cycle + 1;
      if (cycle_limit > 0 && cycle >= cycle_limit)
      begin
         $display("timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("Checks failed");
         $finish;
      end
   end

   // outputs are sampled half a cycle after they change
   always @(negedge tx_clk)
   begin
      if (!reset)
      begin
         if (tx_ack)
            ack_count++;
         if (paused)
            paused_seen = 1'b1;
         if (gmii_tx_en && frame_count < max_frames)
         begin
            if (!capturing)
            begin
               capturing = 1'b1;
               byte_idx  = 0;
               cap_start[frame_count]  = cycle;
               cap_paused[frame_count] = paused;
            end
            if (byte_idx < 256)
            begin
               cap_txd[frame_count][byte_idx] = gmii_txd;
               cap_er[frame_count][byte_idx]  = gmii_tx_er;
            end
            byte_idx++;
         end
         else if (capturing)
         begin
            capturing = 1'b0;
            cap_len[frame_count] = byte_idx;
            cap_end[frame_count] = cycle;
            cap_ifg[frame_count] = ifg;     // gap loaded at the end of this frame
            frame_count++;
         end
      end
   end

   task add_row(input int len, input int seed_off, input int gap, input int err_at,
                input int preq, input int ptime, input int quanta);
      row_len[n_rows]    = len;
      row_seed[n_rows]   = seed_off;
      row_ifg[n_rows]    = gap;
      row_err[n_rows]    = err_at;
      row_preq[n_rows]   = preq;
      row_ptime[n_rows]  = ptime;
      row_quanta[n_rows] = quanta;
      n_rows++;
   endtask

   task expect_equal(input string sig, input int got, input int want);
      checks++;
      assert (got == want)
      else
      begin
         $display("ERR %s got %0h expected %0h", sig, got, want);
         errors++;
      end
   endtask

   task expect_true(input logic cond, input string msg);
      checks++;
      assert (cond)
      else
      begin
         $display("%s", msg);
         errors++;
      end
   endtask

   // reflected crc-32, one data bit at a time
   function automatic logic [31:0] fcs_of_body(input int n);
      logic [31:0] c;
      logic        fb;
      c = 32'hFFFF_FFFF;
      for (int i = 0; i < n; i++)
      begin
         for (int b = 0; b < 8; b++)
         begin
            fb = c[0] ^ body[i][b];
            c  = c >> 1;
            if (fb)
               c = c ^ 32'hEDB8_8320;
         end
      end
      return ~c;
   endfunction

   task make_payload(input int r);
      seed = 32'h95de_2fbc + row_seed[r];
      for (int i = 0; i < row_len[r]; i++)
         payload[i] = gemac_byte_t'($random(seed));
   endtask

   task push_expected(input gemac_byte_t b, input logic er);
      exp_txd[exp_len] = b;
      exp_er[exp_len]  = er;
      exp_len++;
   endtask

   task start_expected();
      exp_len = 0;
      repeat (7) push_expected(8'h55, 1'b0);
      push_expected(8'hD5, 1'b0);              // start-of-frame delimiter
   endtask

   task build_client_body(input int r);
      body_len = (row_len[r] < body_min) ? body_min : row_len[r];
      for (int i = 0; i < body_len; i++)
         body[i] = (i < row_len[r]) ? payload[i] : 8'h00;
   endtask

   task build_pause_body(input pause_time_t ptime);
      logic [143:0] hdr;
      hdr = {48'h01_80_C2_00_00_01, mac_addr, 16'h8808, 16'h0001, ptime};
      body_len = body_min;
      for (int i = 0; i < body_len; i++)
         body[i] = (i < 18) ? hdr[8*(17-i) +: 8] : 8'h00;
   endtask

   task expect_with_fcs();
      logic [31:0] fcs;
      fcs = fcs_of_body(body_len);
      start_expected();
      for (int i = 0; i < body_len; i++)
         push_expected(body[i], 1'b0);
      push_expected(fcs[7:0], 1'b0);           // lowest byte goes out first
      push_expected(fcs[15:8], 1'b0);
      push_expected(fcs[23:16], 1'b0);
      push_expected(fcs[31:24], 1'b0);
   endtask

   task expect_underrun(input int r);
      start_expected();
      for (int i = 0; i <= row_err[r]; i++)
         push_expected(payload[i], 1'b0);
      push_expected(8'h00, 1'b1);              // data under tx_er is don't care
   endtask

   task compare_frame(input int fi);
      expect_equal($sformatf("gmii_tx_en length of frame %0d", fi), cap_len[fi], exp_len);
      if (cap_len[fi] == exp_len)
      begin
         for (int i = 0; i < exp_len; i++)
         begin
            if (!exp_er[i])
               expect_equal($sformatf("gmii_txd frame %0d byte %0d", fi, i),
                            cap_txd[fi][i], exp_txd[i]);
            expect_equal($sformatf("gmii_tx_er frame %0d byte %0d", fi, i),
                         cap_er[fi][i], exp_er[i]);
         end
      end
   endtask

   task drive_client_frame(input int r);
      int last;
      last = (row_err[r] >= 0) ? row_err[r] : row_len[r] - 1;
      tx_data  = payload[0];
      tx_valid = 1'b1;
      @(posedge tx_clk);
      #1;
      while (!tx_ack)                          // first byte is taken at the end of the ack
      begin
         @(posedge tx_clk);
         #1;
      end
      for (int i = 1; i <= last; i++)
      begin
         @(posedge tx_clk);
         #1;
         tx_data  = payload[i];
         tx_error = (i == row_err[r]);
      end
      @(posedge tx_clk);
      #1;
      tx_valid = 1'b0;
      tx_error = 1'b0;
      tx_data  = 8'h00;
   endtask

   task run_test(input int r);
      int first_frame;
      int fi;
      int err_before;
      int ack_before;
      int pulse_cycle;
      first_frame = frame_count;
      err_before  = errors;
      ack_before  = ack_count;
      pulse_cycle = 0;
      @(posedge tx_clk);
      #1;
      ifg         = ifg_t'(row_ifg[r]);
      paused_seen = 1'b0;
      make_payload(r);
      if (row_quanta[r] > 0)
      begin
         pause_quanta = pause_time_t'(row_quanta[r]);
         pause_rcvd   = 1'b1;
         pulse_cycle  = cycle;
         @(posedge tx_clk);
         #1;
         pause_rcvd = 1'b0;
      end
      if (row_preq[r] != 0)
      begin
         pause_time = pause_time_t'(row_ptime[r]);
         pause_req  = 1'b1;                    // latched before tx_valid rises
         @(posedge tx_clk);
         #1;
         pause_req = 1'b0;
      end
      drive_client_frame(r);
      frames_wanted = first_frame + 1 + row_preq[r];
      wait (frame_count >= frames_wanted);
      fi = first_frame;
      if (row_preq[r] != 0)
      begin
         build_pause_body(pause_time_t'(row_ptime[r]));
         expect_with_fcs();
         compare_frame(fi);
         fi++;
      end
      if (row_err[r] >= 0)
         expect_underrun(r);
      else
      begin
         build_client_body(r);
         expect_with_fcs();
      end
      compare_frame(fi);
      for (int f = first_frame; f <= fi; f++)
      begin
         if (f > 0)
            expect_true(cap_start[f] - cap_end[f-1] >= cap_ifg[f-1],
                        $sformatf("frame %0d began %0d idle cycles after the last one, %0d needed",
                                  f, cap_start[f] - cap_end[f-1], cap_ifg[f-1]));
      end
      expect_equal("tx_ack pulse count", ack_count - ack_before, 1);
      if (row_quanta[r] > 0)
      begin
         expect_true(cap_start[fi] - pulse_cycle >= row_quanta[r] * `GEMAC_QUANTUM_CYCLES,
                     "frame started before the received pause time ran out");
         expect_true(paused_seen, "paused never went high during the hold-off");
         expect_true(!cap_paused[fi], "paused still high when the held frame started");
      end
      $display("test %0d: len %0d ifg %0d underrun %0d pause_req %0d quanta %0d -> %s",
               r, row_len[r], row_ifg[r], row_err[r], row_preq[r], row_quanta[r],
               (errors == err_before) ? "ok" : "mismatch");
   endtask

   initial
   begin
      tx_data      = 8'h00;
      tx_valid     = 1'b0;
      tx_error     = 1'b0;
      ifg          = 8'd12;
      mac_addr     = 48'h02_1A_2B_3C_4D_5E;
      pause_req    = 1'b0;
      pause_time   = 16'h0000;
      pause_rcvd   = 1'b0;
      pause_quanta = 16'h0000;

      //      len seed ifg  err  preq ptime     quanta
      add_row(100, 0,   12,  -1,  0,   16'h0000, 0);  // plain frame
      add_row( 20, 1,   12,  -1,  0,   16'h0000, 0);  // padded to 60
      add_row( 64, 2,   40,  -1,  0,   16'h0000, 0);  // follows a gap of 12
      add_row( 80, 3,   12,  -1,  0,   16'h0000, 0);  // follows a gap of 40
      add_row( 90, 4,   12,  30,  0,   16'h0000, 0);  // underrun mid-frame
      add_row( 60, 5,   12,  -1,  0,   16'h0000, 0);  // normal again
      add_row( 46, 6,   12,  -1,  1,   16'h1234, 0);  // pause frame goes first
      add_row( 61, 7,   12,  -1,  0,   16'h0000, 3);  // held off by received pause

      cycle_limit = 0;
      for (int r = 0; r < n_rows; r++)
         cycle_limit += 8 + ((row_len[r] < body_min) ? body_min : row_len[r]) + 4 + row_ifg[r]
                        + ((row_preq[r] != 0) ? 8 + body_min + 4 + row_ifg[r] : 0)
                        + row_quanta[r] * `GEMAC_QUANTUM_CYCLES;
      cycle_limit = 2 * cycle_limit + 200;

      wait (reset === 1'b1);
      wait (reset === 1'b0);
      for (int r = 0; r < n_rows; r++)
         run_test(r);

      $display("tests %0d, checks %0d, errors %0d", n_rows, checks, errors);
      if (errors == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule
